/* build.f */
hdl/ps_pl_regs_pkg.sv
hdl/datamover_pkg.sv
hdl/global_settings.sv
hdl/datamover_cmd_ctrl.sv
hdl/irq_stretch.sv
hdl/ps_pl_ctrl.sv
dv/ps_pl_ctrl_tb.sv

/* Makefile */
# Verilator flow for the ps_pl_ctrl testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module ps_pl_ctrl_tb \
		-Mdir obj_dir -o ps_pl_ctrl_tb

# The log decides pass or fail
run: compile
	./obj_dir/ps_pl_ctrl_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/ps_pl_ctrl_tb.sv */
// Table-driven testbench for ps_pl_ctrl with a register map and command word model
`timescale 1ns/1ps
`default_nettype none

module ps_pl_ctrl_tb;

  // Table operations
  localparam int OP_WRITE = 0;
  localparam int OP_READ  = 1;
  localparam int OP_CMD   = 2;
  // Status byte on page 0 or 1 and accel_irq pulse on page 3
  localparam int OP_EVENT = 3;
  localparam int OP_IRQ   = 4;

  logic        clk;
  logic        rst;
  logic [31:0] set_addr;
  logic [31:0] set_data;
  logic        set_stb;
  logic [31:0] get_addr;
  logic [31:0] get_data;
  logic        h2s_cmd_tvalid;
  logic [71:0] h2s_cmd_tdata;
  logic        h2s_cmd_tready;
  logic        h2s_sts_tvalid;
  logic [7:0]  h2s_sts_tdata;
  logic        h2s_sts_tready;
  logic        s2h_cmd_tvalid;
  logic [71:0] s2h_cmd_tdata;
  logic        s2h_cmd_tready;
  logic        s2h_sts_tvalid;
  logic [7:0]  s2h_sts_tdata;
  logic        s2h_sts_tready;
  logic [3:0]  arcache;
  logic [4:0]  aruser;
  logic [3:0]  awcache;
  logic [4:0]  awuser;
  logic        accel_irq;
  logic        irq;

  // Stimulus table
  int          tab_op [$];
  int          tab_test [$];
  logic [31:0] tab_addr [$];
  logic [31:0] tab_data [$];
  logic [71:0] tab_exp [$];
  int          sum_cycles = 8;
  int          cycle_limit = 0;
  int          cycles = 0;

  // Model state with index 0 for h2s and 1 for s2h
  logic [31:0] m_addr [2];
  logic [22:0] m_btt [2];
  logic        m_pend [2];
  logic [71:0] m_cmd [2];
  logic [7:0]  m_last [2];
  logic [7:0]  m_cnt [2];
  logic [3:0]  m_arcache;
  logic [4:0]  m_aruser;
  logic [3:0]  m_awcache;
  logic [4:0]  m_awuser;

  int errors = 0;
  int test_errs = 0;
  int tests_run = 0;
  int tests_failed = 0;

  ps_pl_ctrl i_dut (
    .clk            (clk),
    .rst            (rst),
    .set_addr       (set_addr),
    .set_data       (set_data),
    .set_stb        (set_stb),
    .get_addr       (get_addr),
    .get_data       (get_data),
    .h2s_cmd_tvalid (h2s_cmd_tvalid),
    .h2s_cmd_tdata  (h2s_cmd_tdata),
    .h2s_cmd_tready (h2s_cmd_tready),
    .h2s_sts_tvalid (h2s_sts_tvalid),
    .h2s_sts_tdata  (h2s_sts_tdata),
    .h2s_sts_tready (h2s_sts_tready),
    .s2h_cmd_tvalid (s2h_cmd_tvalid),
    .s2h_cmd_tdata  (s2h_cmd_tdata),
    .s2h_cmd_tready (s2h_cmd_tready),
    .s2h_sts_tvalid (s2h_sts_tvalid),
    .s2h_sts_tdata  (s2h_sts_tdata),
    .s2h_sts_tready (s2h_sts_tready),
    .arcache        (arcache),
    .aruser         (aruser),
    .awcache        (awcache),
    .awuser         (awuser),
    .accel_irq      (accel_irq),
    .irq            (irq)
  );

  always #10 clk = ~clk;

  // Run limit from the table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic string test_title(input int n);
    case (n)
      1: return "reset values";
      2: return "global registers";
      3: return "commands";
      4: return "status";
      5: return "interrupts";
      default: return "soft reset";
    endcase
  endfunction

  task automatic report_mismatch(input string sig, input logic [71:0] exp,
                                 input logic [71:0] got);
    $display("Fail at %0t ns: %s expected %h, got %h", $time, sig, exp, got);
    errors++;
    test_errs++;
  endtask

  // Everything at reset value
  task automatic model_reset();
    for (int s = 0; s < 2; s++) begin
      m_addr[s] = '0;
      m_btt[s]  = '0;
      m_pend[s] = 1'b0;
      m_cmd[s]  = '0;
      m_last[s] = '0;
      m_cnt[s]  = '0;
    end
    m_arcache = 4'hf;
    m_aruser  = 5'h1f;
    m_awcache = 4'hf;
    m_awuser  = 5'h1f;
  endtask

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    logic        s;
    logic [31:0] val;
    s = addr[12];
    val = 32'h0;
    case (addr[13:12])
      2'd3: val = 32'hdeadbeef;
      2'd2: begin
        case (addr[11:0])
          ps_pl_regs_pkg::OFS_ARCACHE: val = {28'd0, m_arcache};
          ps_pl_regs_pkg::OFS_ARUSER:  val = {27'd0, m_aruser};
          ps_pl_regs_pkg::OFS_AWCACHE: val = {28'd0, m_awcache};
          ps_pl_regs_pkg::OFS_AWUSER:  val = {27'd0, m_awuser};
          default: val = 32'h0;
        endcase
      end
      default: begin
        case (addr[11:0])
          ps_pl_regs_pkg::OFS_ADDR:   val = m_addr[s];
          ps_pl_regs_pkg::OFS_BTT:    val = {9'd0, m_btt[s]};
          // Pending, done count, last status byte
          ps_pl_regs_pkg::OFS_STATUS: val = {15'd0, m_pend[s], m_cnt[s], m_last[s]};
          default: val = 32'h0;
        endcase
      end
    endcase
    return val;
  endfunction

  task automatic add_entry(input int op, input int test, input logic [31:0] addr,
                           input logic [31:0] data, input logic [71:0] exp);
    tab_op.push_back(op);
    tab_test.push_back(test);
    tab_addr.push_back(addr);
    tab_data.push_back(data);
    tab_exp.push_back(exp);
    // Worst-case cycles per operation
    case (op)
      OP_READ: sum_cycles += 1;
      OP_CMD:  sum_cycles += 8;
      OP_IRQ:  sum_cycles += 17;
      default: sum_cycles += 2;
    endcase
  endtask

  task automatic put_write(input int test, input logic [31:0] addr, input logic [31:0] data);
    logic s;
    s = addr[12];
    add_entry(OP_WRITE, test, addr, data, 72'd0);
    if (addr[13] == 1'b0) begin
      case (addr[11:0])
        ps_pl_regs_pkg::OFS_ADDR: m_addr[s] = data;
        ps_pl_regs_pkg::OFS_BTT:  m_btt[s] = data[22:0];
        ps_pl_regs_pkg::OFS_GO: begin
          // Rsvd, tag, address, DRR=0, EOF=1, DSA=0, TYPE=1, BTT
          if (!m_pend[s]) begin
            m_pend[s] = 1'b1;
            m_cmd[s] = {4'h0, data[3:0], m_addr[s], 1'b0, 1'b1, 6'd0, 1'b1, m_btt[s]};
          end
        end
        default: ;
      endcase
    end else if (addr[12] == 1'b0) begin
      case (addr[11:0])
        ps_pl_regs_pkg::OFS_ARCACHE:    m_arcache = data[3:0];
        ps_pl_regs_pkg::OFS_ARUSER:     m_aruser = data[4:0];
        ps_pl_regs_pkg::OFS_AWCACHE:    m_awcache = data[3:0];
        ps_pl_regs_pkg::OFS_AWUSER:     m_awuser = data[4:0];
        ps_pl_regs_pkg::OFS_SOFT_RESET: model_reset();
        default: ;
      endcase
    end
  endtask

  task automatic put_read(input int test, input logic [31:0] addr);
    add_entry(OP_READ, test, addr, 32'd0, 72'(model_read(addr)));
  endtask

  // Expects the pending command or none when nothing is pending
  task automatic put_cmd(input int test, input int s);
    add_entry(OP_CMD, test, 32'(s) << 12, 32'(m_pend[s]), m_cmd[s]);
    m_pend[s] = 1'b0;
  endtask

  task automatic put_event(input int test, input int page, input logic [31:0] data);
    add_entry(OP_EVENT, test, 32'(page) << 12, data, 72'd0);
    if (page < 2) begin
      m_last[page] = data[7:0];
      m_cnt[page] = m_cnt[page] + 8'd1;
    end
  endtask

  task automatic build_table();
    logic [31:0] base;
    put_read(1, 32'h2000);
    put_read(1, 32'h2004);
    put_read(1, 32'h2008);
    put_read(1, 32'h200c);
    put_read(1, 32'h000c);
    put_read(1, 32'h100c);
    put_cmd(1, 0);
    put_cmd(1, 1);
    add_entry(OP_IRQ, 1, 32'd0, 32'd0, 72'd0);
    for (int o = 0; o < 16; o += 4) begin
      put_write(2, 32'h2000 | 32'(o), $urandom);
    end
    for (int o = 0; o < 16; o += 4) begin
      put_read(2, 32'h2000 | 32'(o));
    end
    // Unmapped page swallows writes
    put_write(2, 32'h3000, $urandom);
    put_read(2, 32'h3000);
    put_read(2, 32'h2000);
    for (int s = 0; s < 2; s++) begin
      base = 32'(s) << 12;
      put_write(3, base | 32'h0, $urandom);
      put_write(3, base | 32'h4, $urandom);
      put_read(3, base | 32'h0);
      put_read(3, base | 32'h4);
      put_write(3, base | 32'h8, $urandom);
      // Second GO lands while the first is pending
      put_write(3, base | 32'h8, $urandom);
      put_read(3, base | 32'hc);
      put_cmd(3, s);
      put_cmd(3, s);
      put_read(3, base | 32'hc);
    end
    for (int s = 0; s < 2; s++) begin
      repeat (3) put_event(4, s, $urandom);
      put_read(4, (32'(s) << 12) | 32'hc);
    end
    put_event(5, 1, $urandom);
    add_entry(OP_IRQ, 5, 32'd0, 32'd15, 72'd0);
    put_event(5, 0, $urandom);
    add_entry(OP_IRQ, 5, 32'd0, 32'd0, 72'd0);
    put_event(5, 3, 32'd0);
    add_entry(OP_IRQ, 5, 32'd0, 32'd15, 72'd0);
    put_read(5, 32'h000c);
    put_read(5, 32'h100c);
    put_write(6, 32'h2000, 32'h3);
    put_write(6, 32'h200c, 32'h2);
    put_write(6, 32'h0000, $urandom);
    put_write(6, 32'h0004, $urandom);
    put_write(6, 32'h0008, $urandom);
    put_write(6, 32'h2010, 32'h1);
    put_cmd(6, 0);
    for (int o = 0; o < 16; o += 4) begin
      put_read(6, 32'h2000 | 32'(o));
    end
    put_read(6, 32'h0000);
    put_read(6, 32'h0004);
    put_read(6, 32'h000c);
    put_read(6, 32'h100c);
  endtask

  function automatic logic cmd_valid(input logic s);
    return s ? s2h_cmd_tvalid : h2s_cmd_tvalid;
  endfunction

  function automatic logic [71:0] cmd_data(input logic s);
    return s ? s2h_cmd_tdata : h2s_cmd_tdata;
  endfunction

  task automatic do_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    set_addr = addr;
    set_data = data;
    set_stb = 1'b1;
    @(posedge clk);
    #2;
    set_stb = 1'b0;
  endtask

  // Same-cycle read with the global page also checked on its port
  task automatic do_read(input logic [31:0] addr, input logic [31:0] exp);
    @(posedge clk);
    #2;
    get_addr = addr;
    #1;
    if (get_data !== exp) report_mismatch("get_data", 72'(exp), 72'(get_data));
    if (addr[13:12] == 2'd2) begin
      case (addr[11:0])
        ps_pl_regs_pkg::OFS_ARCACHE:
          if (arcache !== exp[3:0]) report_mismatch("arcache", 72'(exp[3:0]), 72'(arcache));
        ps_pl_regs_pkg::OFS_ARUSER:
          if (aruser !== exp[4:0]) report_mismatch("aruser", 72'(exp[4:0]), 72'(aruser));
        ps_pl_regs_pkg::OFS_AWCACHE:
          if (awcache !== exp[3:0]) report_mismatch("awcache", 72'(exp[3:0]), 72'(awcache));
        ps_pl_regs_pkg::OFS_AWUSER:
          if (awuser !== exp[4:0]) report_mismatch("awuser", 72'(exp[4:0]), 72'(awuser));
        default: ;
      endcase
    end
  endtask

  task automatic check_offer(input logic s, input logic [71:0] exp);
    if (cmd_valid(s) !== 1'b1) report_mismatch(s ? "s2h_cmd_tvalid" : "h2s_cmd_tvalid",
                                               72'd1, 72'(cmd_valid(s)));
    if (cmd_data(s) !== exp) report_mismatch(s ? "s2h_cmd_tdata" : "h2s_cmd_tdata",
                                             exp, cmd_data(s));
  endtask

  task automatic do_cmd(input logic s, input logic expect_cmd, input logic [71:0] exp);
    int hold;
    hold = $urandom % 6;
    if (!expect_cmd) begin
      @(posedge clk);
      #3;
      if (cmd_valid(s) !== 1'b0) report_mismatch(s ? "s2h_cmd_tvalid" : "h2s_cmd_tvalid",
                                                 72'd0, 72'(cmd_valid(s)));
    end else begin
      // Command must wait unchanged under back-pressure
      repeat (hold) begin
        @(posedge clk);
        #3;
        check_offer(s, exp);
      end
      @(posedge clk);
      #2;
      if (s) s2h_cmd_tready = 1'b1;
      else h2s_cmd_tready = 1'b1;
      #1;
      check_offer(s, exp);
      @(posedge clk);
      #2;
      h2s_cmd_tready = 1'b0;
      s2h_cmd_tready = 1'b0;
      #1;
      if (cmd_valid(s) !== 1'b0) report_mismatch(s ? "s2h_cmd_tvalid" : "h2s_cmd_tvalid",
                                                 72'd0, 72'(cmd_valid(s)));
    end
  endtask

  task automatic do_event(input logic [1:0] page, input logic [7:0] data);
    @(posedge clk);
    #2;
    case (page)
      2'd0: begin
        h2s_sts_tvalid = 1'b1;
        h2s_sts_tdata = data;
        if (h2s_sts_tready !== 1'b1) report_mismatch("h2s_sts_tready", 72'd1,
                                                     72'(h2s_sts_tready));
      end
      2'd1: begin
        s2h_sts_tvalid = 1'b1;
        s2h_sts_tdata = data;
        if (s2h_sts_tready !== 1'b1) report_mismatch("s2h_sts_tready", 72'd1,
                                                     72'(s2h_sts_tready));
      end
      default: accel_irq = 1'b1;
    endcase
    @(posedge clk);
    #2;
    h2s_sts_tvalid = 1'b0;
    s2h_sts_tvalid = 1'b0;
    accel_irq = 1'b0;
  endtask

  // irq high for len cycles from the second edge after the event
  task automatic do_irq(input int len);
    logic exp_bit;
    for (int i = 1; i <= 17; i++) begin
      @(posedge clk);
      #3;
      exp_bit = (i <= len);
      if (irq !== exp_bit) report_mismatch("irq", 72'(exp_bit), 72'(irq));
    end
  endtask

  initial begin
    int unsigned seed;
    int cur_test;
    seed = $urandom(67);
    clk = 1'b0;
    rst = 1'b1;
    set_addr = '0;
    set_data = '0;
    set_stb = 1'b0;
    get_addr = '0;
    h2s_cmd_tready = 1'b0;
    h2s_sts_tvalid = 1'b0;
    h2s_sts_tdata = '0;
    s2h_cmd_tready = 1'b0;
    s2h_sts_tvalid = 1'b0;
    s2h_sts_tdata = '0;
    accel_irq = 1'b0;
    model_reset();
    build_table();
    cycle_limit = sum_cycles * 4;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 0; i < tab_op.size(); i++) begin
      cur_test = tab_test[i];
      case (tab_op[i])
        OP_WRITE: do_write(tab_addr[i], tab_data[i]);
        OP_READ:  do_read(tab_addr[i], tab_exp[i][31:0]);
        OP_CMD:   do_cmd(tab_addr[i][12], tab_data[i][0], tab_exp[i]);
        OP_EVENT: do_event(tab_addr[i][13:12], tab_data[i][7:0]);
        default:  do_irq(int'(tab_data[i]));
      endcase
      // Test ends with its last entry
      if (i + 1 == tab_op.size() || tab_test[i + 1] != cur_test) begin
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("Test %0d %s: %s, %0d errors", cur_test, test_title(cur_test),
                 (test_errs == 0) ? "ok" : "failed", test_errs);
        test_errs = 0;
      end
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/ps_pl_ctrl.sv */
// Top level with register page decode, read-data mux, stream controllers and interrupt stretch
`timescale 1ns/1ps
`default_nettype none

module ps_pl_ctrl (
  input  wire logic                                       clk,
  input  wire logic                                       rst,
  // Register bus
  input  wire logic [ps_pl_regs_pkg::ADDR_WIDTH-1:0]      set_addr,
  input  wire logic [ps_pl_regs_pkg::DATA_WIDTH-1:0]      set_data,
  input  wire logic                                       set_stb,
  input  wire logic [ps_pl_regs_pkg::ADDR_WIDTH-1:0]      get_addr,
  output logic      [ps_pl_regs_pkg::DATA_WIDTH-1:0]      get_data,
  // Host to slave, datamover read channel
  output logic                                            h2s_cmd_tvalid,
  output logic      [datamover_pkg::CMD_WIDTH-1:0]        h2s_cmd_tdata,
  input  wire logic                                       h2s_cmd_tready,
  input  wire logic                                       h2s_sts_tvalid,
  input  wire logic [datamover_pkg::STS_WIDTH-1:0]        h2s_sts_tdata,
  output logic                                            h2s_sts_tready,
  // Slave to host, datamover write channel
  output logic                                            s2h_cmd_tvalid,
  output logic      [datamover_pkg::CMD_WIDTH-1:0]        s2h_cmd_tdata,
  input  wire logic                                       s2h_cmd_tready,
  input  wire logic                                       s2h_sts_tvalid,
  input  wire logic [datamover_pkg::STS_WIDTH-1:0]        s2h_sts_tdata,
  output logic                                            s2h_sts_tready,
  // Coherent bus attributes
  output logic      [ps_pl_regs_pkg::CACHE_WIDTH-1:0]     arcache,
  output logic      [ps_pl_regs_pkg::USER_WIDTH-1:0]      aruser,
  output logic      [ps_pl_regs_pkg::CACHE_WIDTH-1:0]     awcache,
  output logic      [ps_pl_regs_pkg::USER_WIDTH-1:0]      awuser,
  // Interrupts
  input  wire logic                                       accel_irq,
  output logic                                            irq
);

  // Page number from the two bits above the page offset
  logic [1:0] set_page;
  logic [1:0] get_page;
  // Per-page write strobes
  logic       stb_h2s;
  logic       stb_s2h;
  logic       stb_global;
  // Per-page read data
  logic [ps_pl_regs_pkg::DATA_WIDTH-1:0] get_data_h2s;
  logic [ps_pl_regs_pkg::DATA_WIDTH-1:0] get_data_s2h;
  logic [ps_pl_regs_pkg::DATA_WIDTH-1:0] get_data_global;
  logic       soft_reset;
  logic       local_rst;
  logic       s2h_done;

  assign set_page = set_addr[ps_pl_regs_pkg::PAGE_WIDTH +: 2];
  assign get_page = get_addr[ps_pl_regs_pkg::PAGE_WIDTH +: 2];

  // Page 3 gets no strobe and drops writes
  assign stb_h2s    = set_stb && (set_page == ps_pl_regs_pkg::PAGE_H2S);
  assign stb_s2h    = set_stb && (set_page == ps_pl_regs_pkg::PAGE_S2H);
  assign stb_global = set_stb && (set_page == ps_pl_regs_pkg::PAGE_GLOBAL);

  // Same-cycle read mux
  always_comb begin
    case (get_page)
      ps_pl_regs_pkg::PAGE_H2S:    get_data = get_data_h2s;
      ps_pl_regs_pkg::PAGE_S2H:    get_data = get_data_s2h;
      ps_pl_regs_pkg::PAGE_GLOBAL: get_data = get_data_global;
      default:                     get_data = ps_pl_regs_pkg::UNMAPPED_DATA;
    endcase
  end

  // Soft reset clears everything below except its own pulse flop
  assign local_rst = rst || soft_reset;

  global_settings i_global (
    .clk        (clk),
    .rst        (rst),
    .set_addr   (set_addr),
    .set_data   (set_data),
    .set_stb    (stb_global),
    .get_addr   (get_addr),
    .get_data   (get_data_global),
    .arcache    (arcache),
    .aruser     (aruser),
    .awcache    (awcache),
    .awuser     (awuser),
    .soft_reset (soft_reset)
  );

  // Memory read commands
  // Read completions are visible through h2s STATUS polling only
  datamover_cmd_ctrl i_h2s (
    .clk        (clk),
    .rst        (local_rst),
    .set_addr   (set_addr),
    .set_data   (set_data),
    .set_stb    (stb_h2s),
    .get_addr   (get_addr),
    .get_data   (get_data_h2s),
    .cmd_tvalid (h2s_cmd_tvalid),
    .cmd_tdata  (h2s_cmd_tdata),
    .cmd_tready (h2s_cmd_tready),
    .sts_tvalid (h2s_sts_tvalid),
    .sts_tdata  (h2s_sts_tdata),
    .sts_tready (h2s_sts_tready),
    .done       ()
  );

  // Memory write commands
  datamover_cmd_ctrl i_s2h (
    .clk        (clk),
    .rst        (local_rst),
    .set_addr   (set_addr),
    .set_data   (set_data),
    .set_stb    (stb_s2h),
    .get_addr   (get_addr),
    .get_data   (get_data_s2h),
    .cmd_tvalid (s2h_cmd_tvalid),
    .cmd_tdata  (s2h_cmd_tdata),
    .cmd_tready (s2h_cmd_tready),
    .sts_tvalid (s2h_sts_tvalid),
    .sts_tdata  (s2h_sts_tdata),
    .sts_tready (s2h_sts_tready),
    .done       (s2h_done)
  );

  // Only write completions interrupt the host
  irq_stretch i_irq (
    .clk       (clk),
    .rst       (local_rst),
    .done      (s2h_done),
    .accel_irq (accel_irq),
    .irq       (irq)
  );

  // Page decode hands each write to one block at most
  a_page_stb_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0({stb_h2s, stb_s2h, stb_global})
  );

endmodule

`default_nettype wire

/* hdl/irq_stretch.sv */
// Interrupt pulse stretcher with restartable down-counter
`timescale 1ns/1ps
`default_nettype none

module irq_stretch (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic done,
  input  wire logic accel_irq,
  output logic      irq
);

  logic [ps_pl_regs_pkg::IRQ_CNT_WIDTH-1:0] irq_cnt;

  // New event reloads the count, even mid-stretch
  always_ff @(posedge clk) begin
    if (rst) begin
      irq_cnt <= '0;
    end else if (done || accel_irq) begin
      irq_cnt <= ps_pl_regs_pkg::IRQ_STRETCH_LEN;
    end else if (irq_cnt != '0) begin
      irq_cnt <= irq_cnt - 1'b1;
    end
  end

  // Registered output, one cycle behind the count
  always_ff @(posedge clk) begin
    if (rst) begin
      irq <= 1'b0;
    end else begin
      irq <= (irq_cnt != '0);
    end
  end

endmodule

`default_nettype wire

/* hdl/datamover_cmd_ctrl.sv */
// Datamover command builder, command holding register and status collector
`timescale 1ns/1ps
`default_nettype none

module datamover_cmd_ctrl (
  input  wire logic                                       clk,
  input  wire logic                                       rst,
  input  wire logic [ps_pl_regs_pkg::ADDR_WIDTH-1:0]      set_addr,
  input  wire logic [ps_pl_regs_pkg::DATA_WIDTH-1:0]      set_data,
  input  wire logic                                       set_stb,
  input  wire logic [ps_pl_regs_pkg::ADDR_WIDTH-1:0]      get_addr,
  output logic      [ps_pl_regs_pkg::DATA_WIDTH-1:0]      get_data,
  output logic                                            cmd_tvalid,
  output logic      [datamover_pkg::CMD_WIDTH-1:0]        cmd_tdata,
  input  wire logic                                       cmd_tready,
  input  wire logic                                       sts_tvalid,
  input  wire logic [datamover_pkg::STS_WIDTH-1:0]        sts_tdata,
  output logic                                            sts_tready,
  output logic                                            done
);

  logic [ps_pl_regs_pkg::PAGE_WIDTH-1:0]       set_ofs;
  logic [ps_pl_regs_pkg::PAGE_WIDTH-1:0]       get_ofs;
  // Programmed transfer
  logic [datamover_pkg::CMD_ADDR_WIDTH-1:0]    addr_reg;
  logic [datamover_pkg::BTT_WIDTH-1:0]         btt_reg;
  // Command handshake
  logic                                        go_wr;
  logic                                        pending;
  logic [datamover_pkg::CMD_WIDTH-1:0]         cmd_word;
  // Status collection
  logic                                        sts_accept;
  logic [datamover_pkg::STS_WIDTH-1:0]         last_sts;
  logic [ps_pl_regs_pkg::DONE_COUNT_WIDTH-1:0] done_cnt;

  assign set_ofs = set_addr[ps_pl_regs_pkg::PAGE_WIDTH-1:0];
  assign get_ofs = get_addr[ps_pl_regs_pkg::PAGE_WIDTH-1:0];

  // GO is dropped while a command is still waiting for the datamover
  assign go_wr = set_stb && (set_ofs == ps_pl_regs_pkg::OFS_GO) && !pending;

  // Address and length registers
  always_ff @(posedge clk) begin
    if (rst) begin
      addr_reg <= '0;
      btt_reg  <= '0;
    end else if (set_stb) begin
      if (set_ofs == ps_pl_regs_pkg::OFS_ADDR) begin
        addr_reg <= set_data[datamover_pkg::CMD_ADDR_WIDTH-1:0];
      end
      // Length keeps only the bits the command word carries
      if (set_ofs == ps_pl_regs_pkg::OFS_BTT) begin
        btt_reg <= set_data[datamover_pkg::BTT_WIDTH-1:0];
      end
    end
  end

  // Command word from programmed fields, tag from GO data
  always_comb begin
    cmd_word = '0;
    cmd_word[datamover_pkg::BTT_LSB +: datamover_pkg::BTT_WIDTH] = btt_reg;
    cmd_word[datamover_pkg::TYPE_BIT] = datamover_pkg::TYPE_INCR;
    cmd_word[datamover_pkg::DSA_LSB +: datamover_pkg::DSA_WIDTH] = datamover_pkg::DSA_NONE;
    cmd_word[datamover_pkg::EOF_BIT] = datamover_pkg::EOF_LAST;
    cmd_word[datamover_pkg::DRR_BIT] = datamover_pkg::DRR_NONE;
    cmd_word[datamover_pkg::ADDR_LSB +: datamover_pkg::CMD_ADDR_WIDTH] = addr_reg;
    cmd_word[datamover_pkg::TAG_LSB +: datamover_pkg::TAG_WIDTH] =
      set_data[datamover_pkg::TAG_WIDTH-1:0];
    // Reserved nibble stays zero
    cmd_word[datamover_pkg::RSVD_LSB +: datamover_pkg::RSVD_WIDTH] = '0;
  end

  // Pending flag is the command valid, cleared on acceptance
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (go_wr) begin
      pending <= 1'b1;
    end else if (pending && cmd_tready) begin
      pending <= 1'b0;
    end
  end

  // Command holding register, only loaded while idle
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_tdata <= '0;
    end else if (go_wr) begin
      cmd_tdata <= cmd_word;
    end
  end

  assign cmd_tvalid = pending;

  // Status side always ready once out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      sts_tready <= 1'b0;
    end else begin
      sts_tready <= 1'b1;
    end
  end

  assign sts_accept = sts_tvalid && sts_tready;
  // One pulse per accepted status byte
  assign done = sts_accept;

  // Last status byte and wrapping completion count
  always_ff @(posedge clk) begin
    if (rst) begin
      last_sts <= '0;
      done_cnt <= '0;
    end else if (sts_accept) begin
      last_sts <= sts_tdata;
      done_cnt <= done_cnt + 1'b1;
    end
  end

  // Read-back, GO and unmapped offsets read zero
  always_comb begin
    get_data = '0;
    case (get_ofs)
      ps_pl_regs_pkg::OFS_ADDR: get_data[datamover_pkg::CMD_ADDR_WIDTH-1:0] = addr_reg;
      ps_pl_regs_pkg::OFS_BTT:  get_data[datamover_pkg::BTT_WIDTH-1:0] = btt_reg;
      ps_pl_regs_pkg::OFS_STATUS: begin
        get_data[datamover_pkg::STS_WIDTH-1:0] = last_sts;
        get_data[datamover_pkg::STS_WIDTH +: ps_pl_regs_pkg::DONE_COUNT_WIDTH] = done_cnt;
        get_data[datamover_pkg::STS_WIDTH + ps_pl_regs_pkg::DONE_COUNT_WIDTH] = pending;
      end
      default: ;
    endcase
  end

  // Under back-pressure the offered command must not move
  a_cmd_hold: assert property (
    @(posedge clk) disable iff (rst)
    cmd_tvalid && !cmd_tready |=> cmd_tvalid && $stable(cmd_tdata)
  );

  // Any reset cycle, hard or soft, withdraws the command
  a_cmd_reset: assert property (
    @(posedge clk) rst |=> !cmd_tvalid
  );

endmodule

`default_nettype wire

/* hdl/global_settings.sv */
// Global page: coherent bus cache and user attributes, soft reset pulse
`timescale 1ns/1ps
`default_nettype none

module global_settings (
  input  wire logic                                         clk,
  input  wire logic                                         rst,
  input  wire logic [ps_pl_regs_pkg::ADDR_WIDTH-1:0]        set_addr,
  input  wire logic [ps_pl_regs_pkg::DATA_WIDTH-1:0]        set_data,
  input  wire logic                                         set_stb,
  input  wire logic [ps_pl_regs_pkg::ADDR_WIDTH-1:0]        get_addr,
  output logic      [ps_pl_regs_pkg::DATA_WIDTH-1:0]        get_data,
  output logic      [ps_pl_regs_pkg::CACHE_WIDTH-1:0]       arcache,
  output logic      [ps_pl_regs_pkg::USER_WIDTH-1:0]        aruser,
  output logic      [ps_pl_regs_pkg::CACHE_WIDTH-1:0]       awcache,
  output logic      [ps_pl_regs_pkg::USER_WIDTH-1:0]        awuser,
  output logic                                              soft_reset
);

  // Offsets within the page
  logic [ps_pl_regs_pkg::PAGE_WIDTH-1:0] set_ofs;
  logic [ps_pl_regs_pkg::PAGE_WIDTH-1:0] get_ofs;

  assign set_ofs = set_addr[ps_pl_regs_pkg::PAGE_WIDTH-1:0];
  assign get_ofs = get_addr[ps_pl_regs_pkg::PAGE_WIDTH-1:0];

  // Attribute registers, cleared by either reset source
  always_ff @(posedge clk) begin
    if (rst || soft_reset) begin
      arcache <= ps_pl_regs_pkg::CACHE_RESET;
      aruser  <= ps_pl_regs_pkg::USER_RESET;
      awcache <= ps_pl_regs_pkg::CACHE_RESET;
      awuser  <= ps_pl_regs_pkg::USER_RESET;
    end else if (set_stb) begin
      case (set_ofs)
        ps_pl_regs_pkg::OFS_ARCACHE: arcache <= set_data[ps_pl_regs_pkg::CACHE_WIDTH-1:0];
        ps_pl_regs_pkg::OFS_ARUSER:  aruser  <= set_data[ps_pl_regs_pkg::USER_WIDTH-1:0];
        ps_pl_regs_pkg::OFS_AWCACHE: awcache <= set_data[ps_pl_regs_pkg::CACHE_WIDTH-1:0];
        ps_pl_regs_pkg::OFS_AWUSER:  awuser  <= set_data[ps_pl_regs_pkg::USER_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  // Soft reset pulse
  // Only the external reset clears this flop, the pulse ends on its own
  // Write during the pulse does not extend it
  always_ff @(posedge clk) begin
    if (rst) begin
      soft_reset <= 1'b0;
    end else begin
      soft_reset <= set_stb && (set_ofs == ps_pl_regs_pkg::OFS_SOFT_RESET) && !soft_reset;
    end
  end

  // Read-back, soft reset and unmapped offsets read zero
  always_comb begin
    get_data = '0;
    case (get_ofs)
      ps_pl_regs_pkg::OFS_ARCACHE: get_data[ps_pl_regs_pkg::CACHE_WIDTH-1:0] = arcache;
      ps_pl_regs_pkg::OFS_ARUSER:  get_data[ps_pl_regs_pkg::USER_WIDTH-1:0]  = aruser;
      ps_pl_regs_pkg::OFS_AWCACHE: get_data[ps_pl_regs_pkg::CACHE_WIDTH-1:0] = awcache;
      ps_pl_regs_pkg::OFS_AWUSER:  get_data[ps_pl_regs_pkg::USER_WIDTH-1:0]  = awuser;
      default: ;
    endcase
  end

  // One-cycle pulse, stream controllers rely on a single reset cycle
  a_soft_reset_single: assert property (
    @(posedge clk) disable iff (rst) soft_reset |=> !soft_reset
  );

endmodule

`default_nettype wire

/* hdl/datamover_pkg.sv */
// Datamover command word field layout and status byte layout
`default_nettype none

package datamover_pkg;

  // Port widths
  localparam int CMD_WIDTH = 72;
  localparam int STS_WIDTH = 8;

  // Field widths
  localparam int BTT_WIDTH      = 23;
  localparam int TAG_WIDTH      = 4;
  localparam int DSA_WIDTH      = 6;
  localparam int CMD_ADDR_WIDTH = 32;
  localparam int RSVD_WIDTH     = 4;

  // Field positions, low to high
  localparam int BTT_LSB  = 0;
  localparam int TYPE_BIT = 23;
  localparam int DSA_LSB  = 24;
  localparam int EOF_BIT  = 30;
  localparam int DRR_BIT  = 31;
  localparam int ADDR_LSB = 32;
  localparam int TAG_LSB  = 64;
  localparam int RSVD_LSB = 68;

  // Fixed field values used by this bridge
  // Incrementing burst
  localparam logic TYPE_INCR = 1'b1;
  // Every command ends its packet
  localparam logic EOF_LAST = 1'b1;
  // No realignment request
  localparam logic DRR_NONE = 1'b0;
  localparam logic [DSA_WIDTH-1:0] DSA_NONE = '0;

  // Status byte, set when the transfer finished without error
  localparam int STS_OKAY_BIT = 7;

endpackage

`default_nettype wire

/* hdl/ps_pl_regs_pkg.sv */
// Register bus widths, page numbers, register offsets and reset values
`default_nettype none

package ps_pl_regs_pkg;

  // Register bus
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // Offset bits inside one page, page number sits in the two bits above
  localparam int PAGE_WIDTH = 12;

  // Page numbers
  localparam logic [1:0] PAGE_H2S    = 2'd0;
  localparam logic [1:0] PAGE_S2H    = 2'd1;
  localparam logic [1:0] PAGE_GLOBAL = 2'd2;

  // Returned for reads of page 3
  localparam logic [DATA_WIDTH-1:0] UNMAPPED_DATA = 32'hdeadbeef;

  // Stream page offsets, same map for h2s and s2h
  localparam logic [PAGE_WIDTH-1:0] OFS_ADDR   = 12'h000;
  localparam logic [PAGE_WIDTH-1:0] OFS_BTT    = 12'h004;
  localparam logic [PAGE_WIDTH-1:0] OFS_GO     = 12'h008;
  localparam logic [PAGE_WIDTH-1:0] OFS_STATUS = 12'h00c;

  // Global page offsets
  localparam logic [PAGE_WIDTH-1:0] OFS_ARCACHE    = 12'h000;
  localparam logic [PAGE_WIDTH-1:0] OFS_ARUSER     = 12'h004;
  localparam logic [PAGE_WIDTH-1:0] OFS_AWCACHE    = 12'h008;
  localparam logic [PAGE_WIDTH-1:0] OFS_AWUSER     = 12'h00c;
  localparam logic [PAGE_WIDTH-1:0] OFS_SOFT_RESET = 12'h010;

  // Coherent bus attributes, defaults request cacheable shared access
  localparam int CACHE_WIDTH = 4;
  localparam int USER_WIDTH  = 5;
  localparam logic [CACHE_WIDTH-1:0] CACHE_RESET = 4'hf;
  localparam logic [USER_WIDTH-1:0]  USER_RESET  = 5'h1f;

  // Completed transfer counter, wraps
  localparam int DONE_COUNT_WIDTH = 8;

  // Interrupt stretch, the interrupt controller misses single-cycle pulses
  localparam int IRQ_CNT_WIDTH = 4;
  localparam logic [IRQ_CNT_WIDTH-1:0] IRQ_STRETCH_LEN = 4'd15;

endpackage

`default_nettype wire
